//--- verilog/disp_pkg.sv
package disp_pkg;

    typedef logic [6:0]  coord_t;
    typedef logic [15:0] rgb_t;

    // ==================================================
    // video timing, 64x32 active
    // ==================================================
    localparam coord_t H_ACT    = 7'd64;
    localparam coord_t H_TOTAL  = 7'd80;
    localparam coord_t HS_START = 7'd68;
    localparam coord_t HS_END   = 7'd72;
    localparam coord_t V_ACT    = 7'd32;
    localparam coord_t V_TOTAL  = 7'd36;
    localparam coord_t VS_START = 7'd33;
    localparam coord_t VS_END   = 7'd35;

    // ==================================================
    // label overlay
    // ==================================================
    localparam coord_t LABEL_X    = 7'd52;
    localparam coord_t LABEL_Y    = 7'd2;
    localparam coord_t LABEL_SIZE = 7'd8;

    // row 0 on top, bit 7 leftmost.
    localparam logic [7:0] LABEL_GLYPH [0:7] = '{
        8'h3c, 8'h66, 8'h60, 8'h3c,
        8'h06, 8'h66, 8'h3c, 8'h00
    };

    localparam rgb_t BAR_COLOR   = 16'h05ff;
    localparam rgb_t LABEL_COLOR = 16'hffff;
    localparam rgb_t BG_COLOR    = 16'h0000;

endpackage

//--- verilog/spec_pkg.sv
package spec_pkg;

    typedef logic [4:0] bin_idx_t;
    typedef logic [7:0] mag_t;

    // ==================================================
    // spectrum layout
    // ==================================================
    localparam int BIN_COUNT    = 24;
    localparam int BAR_WIDTH    = 2;  // pixels per bin.
    localparam int HEIGHT_SHIFT = 3;  // 255 maps to 31 rows.

    // ==================================================
    // write path
    // ==================================================
    // one credit per queue slot.
    localparam int CREDITS = 4;

endpackage

//--- verilog/vid_if.sv
interface vid_if
    import disp_pkg::*;
();

    coord_t x;   // pixel within line.
    coord_t y;   // line within frame.
    logic   de;  // active area.
    logic   hs;
    logic   vs;

    // stage driving the bundle.
    modport src (
        output x,
        output y,
        output de,
        output hs,
        output vs
    );

    // stage consuming it.
    modport snk (
        input x,
        input y,
        input de,
        input hs,
        input vs
    );

endinterface

//--- verilog/video_timing.sv
module video_timing
    import disp_pkg::*;
(
    input  logic pix_clk,
    input  logic rstn,
    vid_if.src   vid
);

    coord_t h_cnt;
    coord_t v_cnt;
    logic   h_last;
    logic   v_last;

    assign h_last = (h_cnt == H_TOTAL - 1'b1);
    assign v_last = (v_cnt == V_TOTAL - 1'b1);

    // ==================================================
    // pixel and line counters
    // ==================================================
    always_ff @(posedge pix_clk or negedge rstn) begin
        if (!rstn) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else begin
            if (h_last) begin
                h_cnt <= '0;
                v_cnt <= v_last ? '0 : v_cnt + 1'b1;  // next line.
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

    // ==================================================
    // registered decode
    // ==================================================
    always_ff @(posedge pix_clk or negedge rstn) begin
        if (!rstn) begin
            vid.x  <= '0;
            vid.y  <= '0;
            vid.de <= 1'b0;
            vid.hs <= 1'b0;
            vid.vs <= 1'b0;
        end else begin
            vid.x  <= h_cnt;
            vid.y  <= v_cnt;
            vid.de <= (h_cnt < H_ACT) && (v_cnt < V_ACT);
            vid.hs <= (h_cnt >= HS_START) && (h_cnt < HS_END);
            vid.vs <= (v_cnt >= VS_START) && (v_cnt < VS_END);
        end
    end

    // x always wraps before the line total.
    a_x_range: assert property (
        @(posedge pix_clk) disable iff (!rstn)
        vid.x < H_TOTAL
    );

endmodule

//--- verilog/bin_store.sv
module bin_store
    import spec_pkg::*;
(
    input  logic     pix_clk,
    input  logic     rstn,
    input  logic     vs,
    input  logic     bin_valid,
    input  bin_idx_t bin_index,
    input  mag_t     bin_mag,
    input  bin_idx_t rd_index,
    output mag_t     rd_mag,
    output logic     credit_return
);

    // write queue.
    bin_idx_t q_idx [CREDITS];
    mag_t     q_mag [CREDITS];
    logic [$clog2(CREDITS)-1:0] wr_ptr;
    logic [$clog2(CREDITS)-1:0] rd_ptr;
    logic [$clog2(CREDITS):0]   q_count;
    logic     drain;

    // bin memory.
    mag_t     mem [BIN_COUNT];
    logic [BIN_COUNT-1:0] written;  // bins that hold a committed value.

    // commit only while vertical sync is up.
    assign drain = vs && (q_count != '0);

    // ==================================================
    // queue
    // ==================================================
    always_ff @(posedge pix_clk) begin
        if (bin_valid) begin
            q_idx[wr_ptr] <= bin_index;
            q_mag[wr_ptr] <= bin_mag;
        end
    end

    always_ff @(posedge pix_clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            q_count       <= '0;
            credit_return <= 1'b0;
        end else begin
            if (bin_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (drain) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({bin_valid, drain})
                2'b10:   q_count <= q_count + 1'b1;
                2'b01:   q_count <= q_count - 1'b1;
                default: q_count <= q_count;
            endcase
            credit_return <= drain;  // one credit back per commit.
        end
    end

    // ==================================================
    // bin memory
    // ==================================================
    always_ff @(posedge pix_clk) begin
        if (drain) begin
            mem[q_idx[rd_ptr]] <= q_mag[rd_ptr];
        end
        if (rd_index < bin_idx_t'(BIN_COUNT) && written[rd_index]) begin
            rd_mag <= mem[rd_index];
        end else begin
            rd_mag <= '0;  // never written reads as zero.
        end
    end

    always_ff @(posedge pix_clk or negedge rstn) begin
        if (!rstn) begin
            written <= '0;
        end else if (drain) begin
            written[q_idx[rd_ptr]] <= 1'b1;
        end
    end

    a_no_overrun: assert property (
        @(posedge pix_clk) disable iff (!rstn)
        bin_valid |-> (q_count != ($clog2(CREDITS)+1)'(CREDITS))
    );

    a_index_range: assert property (
        @(posedge pix_clk) disable iff (!rstn)
        bin_valid |-> (bin_index < bin_idx_t'(BIN_COUNT))
    );

endmodule

//--- verilog/bar_render.sv
module bar_render
    import disp_pkg::*;
    import spec_pkg::*;
(
    input  logic     pix_clk,
    input  logic     rstn,
    vid_if.snk       vin,
    input  mag_t     rd_mag,
    vid_if.src       vout,
    output bin_idx_t rd_index,
    output logic     bar_hit
);

    logic   in_range_q;  // column and line fall on the bar area.
    coord_t row_up_q;    // line counted up from the bottom.
    mag_t   bar_height;

    // bin lookup, data back next cycle.
    assign rd_index = bin_idx_t'(vin.x / BAR_WIDTH);

    // ==================================================
    // coordinate pipeline
    // ==================================================
    always_ff @(posedge pix_clk or negedge rstn) begin
        if (!rstn) begin
            vout.x     <= '0;
            vout.y     <= '0;
            vout.de    <= 1'b0;
            vout.hs    <= 1'b0;
            vout.vs    <= 1'b0;
            in_range_q <= 1'b0;
        end else begin
            vout.x     <= vin.x;
            vout.y     <= vin.y;
            vout.de    <= vin.de;
            vout.hs    <= vin.hs;
            vout.vs    <= vin.vs;
            in_range_q <= (vin.x < coord_t'(BIN_COUNT * BAR_WIDTH)) && (vin.y < V_ACT);
        end
    end

    always_ff @(posedge pix_clk) begin
        row_up_q <= V_ACT - vin.y - 1'b1;
    end

    // ==================================================
    // bar coverage
    // ==================================================
    // aligned with rd_mag, so no extra register.
    assign bar_height = rd_mag >> HEIGHT_SHIFT;
    assign bar_hit    = in_range_q && ({1'b0, row_up_q} < bar_height);

endmodule

//--- verilog/pixel_compose.sv
module pixel_compose
    import disp_pkg::*;
(
    input  logic pix_clk,
    input  logic rstn,
    vid_if.snk   vin,
    input  logic bar_hit,
    output logic vs_out,
    output logic hs_out,
    output logic de_out,
    output rgb_t rgb_data
);

    logic       in_label;
    logic [2:0] gly_row;
    logic [2:0] gly_col;
    logic       glyph_on;
    rgb_t       pix_next;

    // ==================================================
    // label overlay and colour select
    // ==================================================
    always_comb begin
        in_label = (vin.x >= LABEL_X) && (vin.x < LABEL_X + LABEL_SIZE) &&
                   (vin.y >= LABEL_Y) && (vin.y < LABEL_Y + LABEL_SIZE);
        gly_row  = 3'(vin.y - LABEL_Y);
        gly_col  = 3'(vin.x - LABEL_X);
        glyph_on = in_label && LABEL_GLYPH[gly_row][3'd7 - gly_col];  // msb is left.

        if (!vin.de) begin
            pix_next = BG_COLOR;
        end else if (bar_hit) begin
            pix_next = BAR_COLOR;
        end else if (glyph_on) begin
            pix_next = LABEL_COLOR;
        end else begin
            pix_next = BG_COLOR;
        end
    end

    // ==================================================
    // output register
    // ==================================================
    always_ff @(posedge pix_clk or negedge rstn) begin
        if (!rstn) begin
            vs_out   <= 1'b0;
            hs_out   <= 1'b0;
            de_out   <= 1'b0;
            rgb_data <= '0;
        end else begin
            vs_out   <= vin.vs;
            hs_out   <= vin.hs;
            de_out   <= vin.de;
            rgb_data <= pix_next;
        end
    end

    // syncs sit in blanking after both stage delays.
    a_sync_blank: assert property (
        @(posedge pix_clk) disable iff (!rstn)
        de_out |-> !hs_out && !vs_out
    );

endmodule

//--- verilog/spectrum_display.sv
module spectrum_display
    import disp_pkg::*;
    import spec_pkg::*;
(
    input  logic     pix_clk,
    input  logic     rstn,
    input  logic     bin_valid,
    input  bin_idx_t bin_index,
    input  mag_t     bin_mag,
    output logic     credit_return,
    output logic     vs_out,
    output logic     hs_out,
    output logic     de_out,
    output rgb_t     rgb_data
);

    vid_if tg_vid ();  // timing to renderer.
    vid_if br_vid ();  // renderer to composer.

    bin_idx_t rd_index;
    mag_t     rd_mag;
    logic     bar_hit;

    // ==================================================
    // pipeline
    // ==================================================
    video_timing u_timing (
        .pix_clk (pix_clk),
        .rstn    (rstn),
        .vid     (tg_vid.src)
    );

    bin_store u_bins (
        .pix_clk       (pix_clk),
        .rstn          (rstn),
        .vs            (tg_vid.vs),
        .bin_valid     (bin_valid),
        .bin_index     (bin_index),
        .bin_mag       (bin_mag),
        .rd_index      (rd_index),
        .rd_mag        (rd_mag),
        .credit_return (credit_return)
    );

    bar_render u_bars (
        .pix_clk  (pix_clk),
        .rstn     (rstn),
        .vin      (tg_vid.snk),
        .rd_mag   (rd_mag),
        .vout     (br_vid.src),
        .rd_index (rd_index),
        .bar_hit  (bar_hit)
    );

    pixel_compose u_compose (
        .pix_clk  (pix_clk),
        .rstn     (rstn),
        .vin      (br_vid.snk),
        .bar_hit  (bar_hit),
        .vs_out   (vs_out),
        .hs_out   (hs_out),
        .de_out   (de_out),
        .rgb_data (rgb_data)
    );

endmodule

//--- verification/tb_spectrum_display.sv
module tb_spectrum_display
    import disp_pkg::*;
    import spec_pkg::*;
();

    logic     pix_clk;
    logic     rstn;
    logic     bin_valid;
    bin_idx_t bin_index;
    mag_t     bin_mag;
    logic     credit_return;
    logic     vs_out;
    logic     hs_out;
    logic     de_out;
    rgb_t     rgb_data;

    logic [35:0] stim [0:63];  // kind, field a, field b, colour.
    logic [35:0] next_spot [$];
    logic [35:0] cur_spot [$];
    logic [15:0] pending [$];  // index and magnitude per write.
    mag_t        shadow [BIN_COUNT];
    mag_t        next_bins [BIN_COUNT];
    mag_t        cur_bins [BIN_COUNT];
    int          writes_sent = 0;
    int          credits_back = 0;
    int          n_markers = 0;
    int          pix_errors = 0;
    int          sync_errors = 0;
    int          credit_errors = 0;
    int          px = 0;
    int          py = 0;
    int          de_cnt;
    int          hs_rise;
    int          vs_rise;
    int          vs_cyc;
    logic        hs_prev = 1'b0;
    logic        vs_prev = 1'b0;
    logic        check_req = 1'b0;
    logic        frame_active = 1'b0;

    spectrum_display dut (
        .pix_clk       (pix_clk),
        .rstn          (rstn),
        .bin_valid     (bin_valid),
        .bin_index     (bin_index),
        .bin_mag       (bin_mag),
        .credit_return (credit_return),
        .vs_out        (vs_out),
        .hs_out        (hs_out),
        .de_out        (de_out),
        .rgb_data      (rgb_data)
    );

    initial pix_clk = 1'b0;
    always #10 pix_clk = ~pix_clk;

    // bar first, then glyph, then background.
    function automatic rgb_t expect_pixel(input int x, input int y);
        int         height;
        logic [7:0] row;
        height = 0;
        if (x < BIN_COUNT * BAR_WIDTH) begin
            height = int'(cur_bins[x / BAR_WIDTH]) >> HEIGHT_SHIFT;
        end
        if ((int'(V_ACT) - 1 - y) < height) begin
            return BAR_COLOR;
        end
        if (x >= int'(LABEL_X) && x < int'(LABEL_X) + 8 && y >= int'(LABEL_Y) &&
            y < int'(LABEL_Y) + 8) begin
            row = LABEL_GLYPH[y - int'(LABEL_Y)];
            if (row[7 - (x - int'(LABEL_X))]) begin
                return LABEL_COLOR;
            end
        end
        return BG_COLOR;
    endfunction

    task automatic send_write(input bin_idx_t idx, input mag_t mag);
        while ((writes_sent - credits_back) >= CREDITS) begin
            @(negedge pix_clk);  // out of credits.
        end
        bin_valid = 1'b1;
        bin_index = idx;
        bin_mag   = mag;
        writes_sent++;
        pending.push_back({3'b000, idx, mag});
        @(negedge pix_clk);
        bin_valid = 1'b0;
    endtask

    task automatic check_sync_counts();
        assert (de_cnt == int'(H_ACT) * int'(V_ACT)) else begin
            sync_errors++;
            $display("Fail de_count expected %0d actual %0d", int'(H_ACT) * int'(V_ACT), de_cnt);
        end
        assert (hs_rise == int'(V_TOTAL)) else begin
            sync_errors++;
            $display("Fail hs_pulses expected %0d actual %0d", int'(V_TOTAL), hs_rise);
        end
        assert (vs_rise == 1) else begin
            sync_errors++;
            $display("Fail vs_pulses expected 1 actual %0d", vs_rise);
        end
        assert (vs_cyc == int'(VS_END - VS_START) * int'(H_TOTAL)) else begin
            sync_errors++;
            $display("Fail vs_width expected %0d actual %0d",
                     int'(VS_END - VS_START) * int'(H_TOTAL), vs_cyc);
        end
    endtask

    // ==================================================
    // output monitor and frame checker
    // ==================================================
    always @(negedge pix_clk) begin
        if (rstn) begin
            if (credit_return) credits_back++;
            assert (credits_back <= writes_sent && writes_sent - credits_back <= CREDITS) else begin
                credit_errors++;
                $display("credit count broken: %0d sent, %0d returned", writes_sent, credits_back);
            end
            assert (!(credit_return && de_out)) else begin
                credit_errors++;
                $display("bin committed during active video");
            end
            if (de_out && !vs_out && px == 0 && py == 0) begin  // first pixel of a frame.
                if (frame_active) check_sync_counts();
                frame_active = 1'b0;
                if (check_req) begin
                    cur_bins     = next_bins;
                    cur_spot     = next_spot;
                    de_cnt       = 0;
                    hs_rise      = 0;
                    vs_rise      = 0;
                    vs_cyc       = 0;
                    frame_active = 1'b1;
                    check_req    = 1'b0;
                end
            end
            if (frame_active) begin
                if (de_out) de_cnt++;
                if (hs_out && !hs_prev) hs_rise++;
                if (vs_out && !vs_prev) vs_rise++;
                if (vs_out) vs_cyc++;
                if (!de_out) begin
                    assert (rgb_data == BG_COLOR) else begin
                        pix_errors++;
                        $display("Fail blank_pixel expected %h actual %h", BG_COLOR, rgb_data);
                    end
                end
            end
            if (vs_out) begin
                px = 0;
                py = 0;
            end else if (de_out) begin
                if (frame_active) begin
                    assert (rgb_data == expect_pixel(px, py)) else begin
                        pix_errors++;
                        $display("Fail frame_pixel (%0d,%0d) expected %h actual %h",
                                 px, py, expect_pixel(px, py), rgb_data);
                    end
                    foreach (cur_spot[j]) begin
                        if (int'(cur_spot[j][31:24]) == px && int'(cur_spot[j][23:16]) == py) begin
                            assert (rgb_data == cur_spot[j][15:0]) else begin
                                pix_errors++;
                                $display("Fail spot_check (%0d,%0d) expected %h actual %h",
                                         px, py, cur_spot[j][15:0], rgb_data);
                            end
                        end
                    end
                end
                px++;
                if (px == int'(H_ACT)) begin
                    px = 0;
                    py++;
                end
            end
            hs_prev = hs_out;
            vs_prev = vs_out;
        end
    end

    // ==================================================
    // stimulus
    // ==================================================
    initial begin
        int i;
        logic [35:0] ent;
        rstn      = 1'b0;
        bin_valid = 1'b0;
        bin_index = '0;
        bin_mag   = '0;
        for (i = 0; i < 64; i++) stim[i] = '0;
        for (i = 0; i < BIN_COUNT; i++) shadow[i] = '0;
        $readmemh("verification/spectrum_stimulus.txt", stim);
        for (i = 0; i < 64; i++) if (stim[i][35:32] == 4'h2) n_markers++;
        repeat (3) @(negedge pix_clk);
        assert (!credit_return && !vs_out && !hs_out && !de_out && rgb_data == '0) else begin
            sync_errors++;
            $display("outputs not zero during reset");
        end
        rstn = 1'b1;
        i = 0;
        while (i < 64 && stim[i][35:32] != 4'h0) begin
            ent = stim[i];
            i++;
            if (ent[35:32] == 4'h1) begin
                send_write(bin_idx_t'(ent[31:24]), ent[23:16]);
            end else if (ent[35:32] == 4'h2) begin
                while (writes_sent != credits_back) @(negedge pix_clk);
                while (pending.size() > 0) begin
                    shadow[pending[0][12:8]] = pending[0][7:0];  // later write wins.
                    void'(pending.pop_front());
                end
                next_bins = shadow;
                next_spot.delete();
                while (i < 64 && stim[i][35:32] == 4'h3) begin
                    next_spot.push_back(stim[i]);
                    i++;
                end
                check_req = 1'b1;
                while (check_req) @(negedge pix_clk);  // frame under way.
            end
        end
        while (frame_active) @(negedge pix_clk);
        assert (writes_sent == credits_back) else begin
            credit_errors++;
            $display("Fail credit_total expected %0d actual %0d", writes_sent, credits_back);
        end
        $display("errors: pixel %0d, sync %0d, credit %0d", pix_errors, sync_errors, credit_errors);
        if (pix_errors + sync_errors + credit_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #1;
        #((n_markers + 2) * int'(H_TOTAL) * int'(V_TOTAL) * 20);
        $display("watchdog expired before all frames were checked");
        $display("TEST FAILED");
        $finish;
    end

endmodule

//--- verification/spectrum_stimulus.txt
// kind_a_b_rgb. kind 1 write (a index, b magnitude), 2 frame marker,
// kind 3 spot check in the frame of the marker above (a x, b y, rgb expected).
2_00_00_0000 // reset frame
3_00_1f_0000
3_36_02_ffff
3_34_02_0000
1_00_ff_0000 // full height bar
1_05_40_0000
1_05_80_0000 // overrides bin 5
1_17_08_0000
1_0c_20_0000
1_03_10_0000
2_00_00_0000
3_00_01_05ff
3_01_00_0000
3_0a_10_05ff
3_0b_0f_0000
3_2f_1f_05ff
3_2f_1e_0000
3_18_1c_05ff
3_36_02_ffff
1_05_00_0000 // clear bin 5
1_00_10_0000
1_14_ff_0000
2_00_00_0000
3_0a_1f_0000
3_00_1e_05ff
3_00_1d_0000
3_28_05_05ff
3_2f_1f_05ff
3_3f_1f_0000

//--- spectrum_display.f
verilog/disp_pkg.sv
verilog/spec_pkg.sv
verilog/vid_if.sv
verilog/video_timing.sv
verilog/bin_store.sv
verilog/bar_render.sv
verilog/pixel_compose.sv
verilog/spectrum_display.sv
verification/tb_spectrum_display.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the spectrum display testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_spectrum_display \
    -f spectrum_display.f \
    -o sim_spectrum_display

./obj_dir/sim_spectrum_display > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log || ! grep -q "TEST PASSED" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
